// File: tb.f
+incdir+hdl
+incdir+tb
hdl/pbus_pkg.sv
hdl/pbus_req_intake.sv
hdl/pbus_timer.sv
hdl/pbus_gpio.sv
hdl/pbus_resp_mux.sv
hdl/peripheral_bus.sv
tb/tb_peripheral_bus.sv

// File: run_sim.sh
#!/bin/sh
# build and run the peripheral bus testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_peripheral_bus -f tb.f \
    --Mdir obj_dir -o sim_peripheral_bus

if ! ./obj_dir/sim_peripheral_bus > sim.log 2>&1; then
    cat sim.log
    exit 1
fi
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0

// File: tb/tb_pbus_tasks.svh
/*
 * testbench helpers
 * host side req/ack access tasks, value check and reference model state
 */
`ifndef TB_PBUS_TASKS_SVH
`define TB_PBUS_TASKS_SVH

localparam int ACK_LIMIT = 50;              // cycles before an access counts as lost

int unsigned error_count = 0;
int unsigned check_count = 0;

// reference model of the writable registers
logic [`PBUS_GPIO_W-1:0]  exp_gpio_out;
logic [`PBUS_GPIO_W-1:0]  exp_gpio_irq_en;
logic [`PBUS_DATA_W-1:0]  exp_tim_ctrl [2];
logic [`PBUS_DATA_W-1:0]  exp_tim_load [2];

task automatic clear_model();
    exp_gpio_out    = '0;                   // reset values of all slaves
    exp_gpio_irq_en = '0;
    exp_tim_ctrl    = '{default: '0};
    exp_tim_load    = '{default: '0};
endtask

// slave in addr[11:8], register in addr[3:2]
function automatic logic [`PBUS_ADDR_W-1:0] make_addr(input int slv, input logic [1:0] reg_off);
    return {4'h0, 4'(slv), 4'h0, reg_off, 2'b00};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
        error_count++;
        $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
endtask

task automatic wait_cycles(input int n);
    repeat (n) @(negedge clock);
endtask

// one full four-phase handshake, starts and ends on a falling edge
task automatic run_access(input pbus_op_e op, input logic [`PBUS_ADDR_W-1:0] addr,
                          input logic [`PBUS_DATA_W-1:0] wdata, output pbus_rsp_t rsp);
    int edges;
    edges = 0;
    @(negedge clock);
    check_value("ack_idle", 32'd0, 32'(ack));   // no new req while ack is up
    req_payload = '{op: op, addr: addr, wdata: wdata};
    req         = 1'b1;
    do begin
        @(negedge clock);
        edges++;
    end while (ack !== 1'b1 && edges < ACK_LIMIT);
    if (ack !== 1'b1) begin
        error_count++;
        $display("ERROR: no ack within %0d cycles for address 0x%04h", ACK_LIMIT, addr);
        rsp = '0;
        req = 1'b0;
    end else begin
        check_value("ack_latency", 32'd4, 32'(edges - 1));  // edges after the sampling one
        rsp = rsp_data;
        req = 1'b0;
        @(negedge clock);
        check_value("ack_release", 32'd0, 32'(ack));
    end
endtask

task automatic write_reg(input int slv, input logic [1:0] reg_off,
                         input logic [`PBUS_DATA_W-1:0] data);
    pbus_rsp_t rsp;
    run_access(PBUS_WRITE, make_addr(slv, reg_off), data, rsp);
    check_value("write_resp", 32'(PBUS_OKAY), 32'(rsp.resp));
    check_value("write_rdata", 32'd0, rsp.rdata);   // writes answer with zero
endtask

task automatic read_reg(input int slv, input logic [1:0] reg_off,
                        output logic [`PBUS_DATA_W-1:0] data);
    pbus_rsp_t rsp;
    run_access(PBUS_READ, make_addr(slv, reg_off), '0, rsp);
    check_value("read_resp", 32'(PBUS_OKAY), 32'(rsp.resp));
    data = rsp.rdata;
endtask

`endif

// File: tb/tb_peripheral_bus.sv
/*
 * peripheral bus testbench
 * random gpio, timer and decode error traffic checked against a register model
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module tb_peripheral_bus;
    import pbus_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int NUM_OPS       = 200;
    localparam int CYCLES_PER_OP = 40;
    localparam int SLV_GPIO      = 0;       // slave field values
    localparam int SLV_TIM0      = 1;

    logic                      clock;
    logic                      rst_n;
    logic                      req;
    pbus_req_t                 req_payload;
    logic                      ack;
    pbus_rsp_t                 rsp_data;
    logic [`PBUS_GPIO_W-1:0]   gpio_in;
    logic [`PBUS_GPIO_W-1:0]   gpio_out;
    logic [`PBUS_NUM_IRQ-1:0]  int_vec;     // {tim1, tim0, gpio}
    integer                    seed = 32'h2dfc675e;

    `include "tb_pbus_tasks.svh"

    peripheral_bus i_peripheral_bus (
        .clock_i       ( clock       ),
        .rst_n_i       ( rst_n       ),
        .req_i         ( req         ),
        .req_payload_i ( req_payload ),
        .ack_o         ( ack         ),
        .rsp_o         ( rsp_data    ),
        .gpio_in_i     ( gpio_in     ),
        .gpio_out_o    ( gpio_out    ),
        .int_o         ( int_vec     )
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        repeat (NUM_OPS * CYCLES_PER_OP) @(posedge clock);
        $display("ERROR: run did not finish within %0d cycles", NUM_OPS * CYCLES_PER_OP);
        $display("STATUS: FAIL");
        $finish;
    end

    // one-shot run of timer idx, slave idx+1, int bit idx+1
    task automatic run_timer(input int idx);
        int                       slv;
        int                       load;
        logic [`PBUS_DATA_W-1:0]  rdata;
        slv  = idx + 1;
        load = int'($unsigned($random(seed)) % 20) + 1;
        write_reg(slv, `PBUS_TIM_LOAD, 32'(load));
        exp_tim_load[idx] = 32'(load);
        write_reg(slv, `PBUS_TIM_CTRL, (32'd1 << `PBUS_TIM_EN) | (32'd1 << `PBUS_TIM_IRQ_EN));
        exp_tim_ctrl[idx] = 32'd1 << `PBUS_TIM_IRQ_EN;   // en drops at expiry
        wait_cycles(load + 10);
        check_value("timer_int", 32'd1, 32'(int_vec[slv]));
        check_value("timer_other_int", 32'd0, 32'(int_vec[3 - slv]));
        check_value("timer_gpio_int", 32'd0, 32'(int_vec[0]));
        read_reg(slv, `PBUS_TIM_STATUS, rdata);
        check_value("timer_status", 32'd1, rdata);
        read_reg(slv, `PBUS_TIM_CTRL, rdata);
        check_value("timer_ctrl", exp_tim_ctrl[idx], rdata);
        read_reg(slv, `PBUS_TIM_COUNT, rdata);
        check_value("timer_count", 32'd0, rdata);   // stopped at zero
        write_reg(slv, `PBUS_TIM_STATUS, 32'd1);
        read_reg(slv, `PBUS_TIM_STATUS, rdata);
        check_value("timer_status_clr", 32'd0, rdata);
        check_value("timer_int_clr", 32'd0, 32'(int_vec[slv]));
    endtask

    initial begin : main
        logic [31:0]              data;
        logic [`PBUS_DATA_W-1:0]  rdata;
        logic [`PBUS_GPIO_W-1:0]  flip;
        logic [`PBUS_ADDR_W-1:0]  addr;
        pbus_op_e                 op;
        pbus_rsp_t                rsp;
        rst_n       = 1'b0;
        req         = 1'b0;
        req_payload = '0;
        gpio_in     = '0;
        clear_model();
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_value("reset_ack", 32'd0, 32'(ack));
        check_value("reset_int", 32'd0, 32'(int_vec));

        //////////////////////////////////////////////////
        // gpio output and input
        //////////////////////////////////////////////////
        repeat (8) begin
            data = $random(seed);
            write_reg(SLV_GPIO, `PBUS_GPIO_OUT, data);
            exp_gpio_out = data[`PBUS_GPIO_W-1:0];      // upper bits dropped
            read_reg(SLV_GPIO, `PBUS_GPIO_OUT, rdata);
            check_value("gpio_out_read", 32'(exp_gpio_out), rdata);
            check_value("gpio_out_pins", 32'(exp_gpio_out), 32'(gpio_out));
        end
        repeat (6) begin
            data = $random(seed);
            @(negedge clock);
            gpio_in = data[`PBUS_GPIO_W-1:0];
            wait_cycles(3);                             // through the synchronizer
            read_reg(SLV_GPIO, `PBUS_GPIO_IN, rdata);
            check_value("gpio_in_read", 32'(gpio_in), rdata);
        end
        check_value("gpio_int_masked", 32'd0, 32'(int_vec[0]));
        data = $random(seed);
        exp_gpio_irq_en = data[`PBUS_GPIO_W-1:0] | 8'h01;
        write_reg(SLV_GPIO, `PBUS_GPIO_IRQ_EN, 32'(exp_gpio_irq_en));
        read_reg(SLV_GPIO, `PBUS_GPIO_IRQ_EN, rdata);
        check_value("gpio_irq_en", 32'(exp_gpio_irq_en), rdata);
        data = $random(seed);
        flip = data[`PBUS_GPIO_W-1:0] | 8'h01;          // bit 0 is always enabled
        @(negedge clock);
        gpio_in = gpio_in ^ flip;
        wait_cycles(3);
        check_value("gpio_int_set", 32'd1, 32'(int_vec[0]));
        read_reg(SLV_GPIO, `PBUS_GPIO_STATUS, rdata);
        check_value("gpio_status", 32'(flip & exp_gpio_irq_en), rdata);
        write_reg(SLV_GPIO, `PBUS_GPIO_STATUS, 32'hff);
        read_reg(SLV_GPIO, `PBUS_GPIO_STATUS, rdata);
        check_value("gpio_status_clr", 32'd0, rdata);
        check_value("gpio_int_clr", 32'd0, 32'(int_vec[0]));

        //////////////////////////////////////////////////
        // timers, then a COUNT write on tim0
        //////////////////////////////////////////////////
        run_timer(0);
        run_timer(1);
        write_reg(SLV_TIM0, `PBUS_TIM_COUNT, $random(seed));
        read_reg(SLV_TIM0, `PBUS_TIM_COUNT, rdata);
        check_value("count_read_only", 32'd0, rdata);
        read_reg(SLV_TIM0, `PBUS_TIM_LOAD, rdata);
        check_value("load_kept", exp_tim_load[0], rdata);
        run_timer(0);

        //////////////////////////////////////////////////
        // unmapped addresses
        //////////////////////////////////////////////////
        repeat (10) begin
            data = $random(seed);
            addr = data[`PBUS_ADDR_W-1:0];
            if (addr[15:12] == 4'h0 && addr[11:8] < 4'd3)
                addr[15] = 1'b1;                        // push it out of the map
            op = data[16] ? PBUS_WRITE : PBUS_READ;
            run_access(op, addr, $random(seed), rsp);
            check_value("decerr_resp", 32'(PBUS_DECERR), 32'(rsp.resp));
            check_value("decerr_rdata", 32'd0, rsp.rdata);
        end
        read_reg(SLV_GPIO, `PBUS_GPIO_OUT, rdata);
        check_value("decerr_gpio_out", 32'(exp_gpio_out), rdata);
        check_value("decerr_gpio_pins", 32'(exp_gpio_out), 32'(gpio_out));
        read_reg(SLV_GPIO, `PBUS_GPIO_IRQ_EN, rdata);
        check_value("decerr_gpio_irq_en", 32'(exp_gpio_irq_en), rdata);
        for (int i = 0; i < 2; i++) begin
            read_reg(i + 1, `PBUS_TIM_LOAD, rdata);
            check_value("decerr_tim_load", exp_tim_load[i], rdata);
            read_reg(i + 1, `PBUS_TIM_CTRL, rdata);
            check_value("decerr_tim_ctrl", exp_tim_ctrl[i], rdata);
        end
        check_value("final_int", 32'd0, 32'(int_vec));

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_peripheral_bus

// File: hdl/peripheral_bus.sv
/*
 * peripheral bus top
 * req/ack host port in front of gpio, tim0 and tim1, merged interrupts
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module peripheral_bus (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  pbus_pkg::pbus_req_t       req_payload_i,
    output logic                      ack_o,
    output pbus_pkg::pbus_rsp_t       rsp_o,
    input  logic [`PBUS_GPIO_W-1:0]   gpio_in_i,
    output logic [`PBUS_GPIO_W-1:0]   gpio_out_o,
    output logic [`PBUS_NUM_IRQ-1:0]  int_o
);
    import pbus_pkg::*;

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////

    pbus_acc_t                 acc;         // broadcast to all slaves
    logic [`PBUS_NUM_SLV-1:0]  acc_en;      // 0 gpio, 1 tim0, 2 tim1
    logic                      dec_err;
    logic [`PBUS_NUM_SLV-1:0]  rd_valid;
    logic [`PBUS_DATA_W-1:0]   rdata [`PBUS_NUM_SLV];
    logic                      rsp_valid;
    pbus_rsp_t                 rsp;
    logic                      gpio_int;
    logic                      tim0_int;
    logic                      tim1_int;

    assign int_o = {tim1_int, tim0_int, gpio_int};

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    pbus_req_intake intake_u (
        .clock_i       ( clock_i       ),
        .rst_n_i       ( rst_n_i       ),
        .req_i         ( req_i         ),
        .req_payload_i ( req_payload_i ),
        .ack_o         ( ack_o         ),
        .rsp_o         ( rsp_o         ),
        .acc_o         ( acc           ),
        .acc_en_o      ( acc_en        ),
        .dec_err_o     ( dec_err       ),
        .rsp_valid_i   ( rsp_valid     ),
        .rsp_i         ( rsp           )
    );

    //////////////////////////////////////////////////
    // slaves
    //////////////////////////////////////////////////

    pbus_gpio gpio_u (
        .clock_i    ( clock_i     ),
        .rst_n_i    ( rst_n_i     ),
        .acc_i      ( acc         ),
        .acc_en_i   ( acc_en[0]   ),
        .rd_valid_o ( rd_valid[0] ),
        .rdata_o    ( rdata[0]    ),
        .gpio_in_i  ( gpio_in_i   ),
        .gpio_out_o ( gpio_out_o  ),
        .irq_o      ( gpio_int    )
    );

    pbus_timer tim0_u (
        .clock_i    ( clock_i     ),
        .rst_n_i    ( rst_n_i     ),
        .acc_i      ( acc         ),
        .acc_en_i   ( acc_en[1]   ),
        .rd_valid_o ( rd_valid[1] ),
        .rdata_o    ( rdata[1]    ),
        .irq_o      ( tim0_int    )
    );

    pbus_timer tim1_u (
        .clock_i    ( clock_i     ),
        .rst_n_i    ( rst_n_i     ),
        .acc_i      ( acc         ),
        .acc_en_i   ( acc_en[2]   ),
        .rd_valid_o ( rd_valid[2] ),
        .rdata_o    ( rdata[2]    ),
        .irq_o      ( tim1_int    )
    );

    //////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////

    pbus_resp_mux resp_mux_u (
        .clock_i     ( clock_i   ),
        .rst_n_i     ( rst_n_i   ),
        .rd_valid_i  ( rd_valid  ),
        .rdata_i     ( rdata     ),
        .dec_err_i   ( dec_err   ),
        .rsp_valid_o ( rsp_valid ),
        .rsp_o       ( rsp       )
    );

endmodule : peripheral_bus

// File: hdl/pbus_resp_mux.sv
/*
 * response merge
 * ORs slave read data, folds in the decode error, registers the result
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module pbus_resp_mux (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic [`PBUS_NUM_SLV-1:0]  rd_valid_i,
    input  logic [`PBUS_DATA_W-1:0]   rdata_i [`PBUS_NUM_SLV],
    input  logic                      dec_err_i,
    output logic                      rsp_valid_o,
    output pbus_pkg::pbus_rsp_t       rsp_o
);
    import pbus_pkg::*;

    logic [`PBUS_DATA_W-1:0] rdata_or;
    logic                    dec_err_q;     // error lined up with slave answers

    // only the answering slave contributes
    always_comb begin
        rdata_or = '0;
        for (int i = 0; i < `PBUS_NUM_SLV; i++) begin
            if (rd_valid_i[i]) rdata_or = rdata_or | rdata_i[i];
        end
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_err_q   <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            dec_err_q   <= dec_err_i;             // stands in for the slave stage
            rsp_valid_o <= (|rd_valid_i) || dec_err_q;
        end
    end

    always_ff @(posedge clock_i) begin
        if (dec_err_q) begin
            rsp_o.resp  <= PBUS_DECERR;
            rsp_o.rdata <= '0;                  // nothing behind the address
        end else begin
            rsp_o.resp  <= PBUS_OKAY;
            rsp_o.rdata <= rdata_or;
        end
    end

    // intake issues one strobe per request, so at most one answer arrives
    a_single_source: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $onehot0({rd_valid_i, dec_err_i}));

endmodule : pbus_resp_mux

// File: hdl/pbus_gpio.sv
/*
 * gpio block
 * output register, two-flop input synchronizer and change interrupt
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module pbus_gpio (
    input  logic                     clock_i,
    input  logic                     rst_n_i,
    input  pbus_pkg::pbus_acc_t      acc_i,
    input  logic                     acc_en_i,
    output logic                     rd_valid_o,
    output logic [`PBUS_DATA_W-1:0]  rdata_o,
    input  logic [`PBUS_GPIO_W-1:0]  gpio_in_i,
    output logic [`PBUS_GPIO_W-1:0]  gpio_out_o,
    output logic                     irq_o
);
    import pbus_pkg::*;

    logic [`PBUS_GPIO_W-1:0]  out_q;
    logic [`PBUS_GPIO_W-1:0]  irq_en_q;
    logic [`PBUS_GPIO_W-1:0]  status_q;      // sticky change flags
    logic [`PBUS_GPIO_W-1:0]  sync1_q;
    logic [`PBUS_GPIO_W-1:0]  sync2_q;       // synchronized inputs
    logic [`PBUS_GPIO_W-1:0]  prev_q;        // last synchronized value
    logic [`PBUS_GPIO_W-1:0]  changed;
    logic [`PBUS_GPIO_W-1:0]  rd_mux;
    logic                     wr_en;

    assign wr_en   = acc_en_i && (acc_i.op == PBUS_WRITE);
    assign changed = (sync2_q ^ prev_q) & irq_en_q;   // only enabled bits

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            irq_en_q <= '0;
            status_q <= '0;
        end else begin
            if (wr_en && acc_i.reg_off == `PBUS_GPIO_OUT)    out_q    <= acc_i.wdata[`PBUS_GPIO_W-1:0];
            if (wr_en && acc_i.reg_off == `PBUS_GPIO_IRQ_EN) irq_en_q <= acc_i.wdata[`PBUS_GPIO_W-1:0];
            if (wr_en && acc_i.reg_off == `PBUS_GPIO_STATUS)
                status_q <= (status_q & ~acc_i.wdata[`PBUS_GPIO_W-1:0]) | changed;  // w1c
            else
                status_q <= status_q | changed;
        end
    end

    assign gpio_out_o = out_q;
    assign irq_o      = |status_q;

    always_comb begin
        case (acc_i.reg_off)
            `PBUS_GPIO_OUT:    rd_mux = out_q;
            `PBUS_GPIO_IN:     rd_mux = sync2_q;
            `PBUS_GPIO_IRQ_EN: rd_mux = irq_en_q;
            default:           rd_mux = status_q;   // `PBUS_GPIO_STATUS
        endcase
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) rd_valid_o <= 1'b0;
        else          rd_valid_o <= acc_en_i;
    end

    always_ff @(posedge clock_i) begin
        rdata_o <= (acc_en_i && acc_i.op == PBUS_READ) ? `PBUS_DATA_W'(rd_mux) : '0;
    end

endmodule : pbus_gpio

// File: hdl/pbus_timer.sv
/*
 * down-counting timer
 * one-shot or auto-reload from LOAD, pending flag with maskable interrupt
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module pbus_timer (
    input  logic                     clock_i,
    input  logic                     rst_n_i,
    input  pbus_pkg::pbus_acc_t      acc_i,
    input  logic                     acc_en_i,
    output logic                     rd_valid_o,
    output logic [`PBUS_DATA_W-1:0]  rdata_o,
    output logic                     irq_o
);
    import pbus_pkg::*;

    logic [`PBUS_TIM_IRQ_EN:0]  ctrl_q;     // irq_en, reload, en
    logic [`PBUS_DATA_W-1:0]    load_q;
    logic [`PBUS_DATA_W-1:0]    count_q;
    logic                       pending_q;
    logic                       wr_en;
    logic                       expire;
    logic                       pend_clr;
    logic [`PBUS_DATA_W-1:0]    rd_mux;

    assign wr_en    = acc_en_i && (acc_i.op == PBUS_WRITE);
    assign expire   = ctrl_q[`PBUS_TIM_EN] && (count_q == '0);
    assign pend_clr = wr_en && (acc_i.reg_off == `PBUS_TIM_STATUS) && acc_i.wdata[0];

    //////////////////////////////////////////////////
    // counter and registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q  <= '0;
            load_q  <= '0;
            count_q <= '0;
        end else begin
            if (expire) begin
                if (ctrl_q[`PBUS_TIM_RELOAD]) count_q <= load_q;   // auto-reload
                else ctrl_q[`PBUS_TIM_EN] <= 1'b0;                // one-shot stops
            end else if (ctrl_q[`PBUS_TIM_EN]) begin
                count_q <= count_q - 1'b1;
            end
            if (wr_en) begin
                case (acc_i.reg_off)
                    `PBUS_TIM_CTRL: begin
                        ctrl_q <= acc_i.wdata[`PBUS_TIM_IRQ_EN:0];
                        if (acc_i.wdata[`PBUS_TIM_EN] && !ctrl_q[`PBUS_TIM_EN])
                            count_q <= load_q;         // start from LOAD
                    end
                    `PBUS_TIM_LOAD: load_q <= acc_i.wdata;
                    default: ;                          // COUNT ignores writes
                endcase
            end
        end
    end

    // set wins over a same-cycle clear
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) pending_q <= 1'b0;
        else          pending_q <= (pending_q && !pend_clr) || expire;
    end

    assign irq_o = pending_q && ctrl_q[`PBUS_TIM_IRQ_EN];

    //////////////////////////////////////////////////
    // read path
    //////////////////////////////////////////////////

    always_comb begin
        case (acc_i.reg_off)
            `PBUS_TIM_CTRL:  rd_mux = `PBUS_DATA_W'(ctrl_q);
            `PBUS_TIM_LOAD:  rd_mux = load_q;
            `PBUS_TIM_COUNT: rd_mux = count_q;
            default:         rd_mux = `PBUS_DATA_W'(pending_q);   // status
        endcase
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) rd_valid_o <= 1'b0;
        else          rd_valid_o <= acc_en_i;   // writes answer too
    end

    always_ff @(posedge clock_i) begin
        rdata_o <= (acc_en_i && acc_i.op == PBUS_READ) ? rd_mux : '0;
    end

    // a raised interrupt holds until a STATUS clear or a CTRL rewrite
    a_irq_sticky: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        irq_o && !pend_clr && !(wr_en && acc_i.reg_off == `PBUS_TIM_CTRL) |=> irq_o);

endmodule : pbus_timer

// File: hdl/pbus_req_intake.sv
/*
 * request intake
 * four-phase req/ack host port, slave decode and single access sequencing
 */
`timescale 1ns/1ps
`include "pbus_macros.svh"

module pbus_req_intake (
    input  logic                      clock_i,
    input  logic                      rst_n_i,
    input  logic                      req_i,
    input  pbus_pkg::pbus_req_t       req_payload_i,
    output logic                      ack_o,
    output pbus_pkg::pbus_rsp_t       rsp_o,
    output pbus_pkg::pbus_acc_t       acc_o,
    output logic [`PBUS_NUM_SLV-1:0]  acc_en_o,
    output logic                      dec_err_o,
    input  logic                      rsp_valid_i,
    input  pbus_pkg::pbus_rsp_t       rsp_i
);
    import pbus_pkg::*;

    pbus_state_e               state_q;
    pbus_req_t                 req_q;       // captured request
    pbus_rsp_t                 rsp_q;       // held for the host
    logic [`PBUS_SLV_W-1:0]    slv_sel;
    logic                      mapped;
    logic [`PBUS_NUM_SLV-1:0]  slv_onehot;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign slv_sel = req_q.addr[`PBUS_SLV_LSB +: `PBUS_SLV_W];
    assign mapped  = (req_q.addr[`PBUS_ADDR_W-1:`PBUS_SLV_LSB+`PBUS_SLV_W] == '0)
                  && (slv_sel < `PBUS_NUM_SLV);       // upper bits clear, slave exists

    always_comb begin
        for (int i = 0; i < `PBUS_NUM_SLV; i++) begin
            slv_onehot[i] = mapped && (slv_sel == `PBUS_SLV_W'(i));
        end
    end

    assign acc_o = '{op:      req_q.op,
                     reg_off: req_q.addr[`PBUS_REG_LSB +: `PBUS_REG_W],
                     wdata:   req_q.wdata};

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            acc_en_o  <= '0;
            dec_err_o <= 1'b0;
        end else begin
            acc_en_o  <= '0;                   // strobes are single cycle
            dec_err_o <= 1'b0;
            case (state_q)
                IDLE:     if (req_i) state_q <= ACCESS;
                ACCESS: begin
                    acc_en_o  <= slv_onehot;
                    dec_err_o <= ~mapped;
                    state_q   <= WAIT_RSP;
                end
                WAIT_RSP: if (rsp_valid_i) state_q <= HOLD_ACK;
                HOLD_ACK: if (!req_i) state_q <= IDLE;   // host released req
                default:  state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (state_q == IDLE && req_i) req_q <= req_payload_i;
        if (state_q == WAIT_RSP && rsp_valid_i) rsp_q <= rsp_i;
    end

    assign ack_o = (state_q == HOLD_ACK);  // stays up under back-pressure
    assign rsp_o = rsp_q;

    //////////////////////////////////////////////////
    // assertions
    //////////////////////////////////////////////////

    a_one_target: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        $onehot0({acc_en_o, dec_err_o}));     // one slave or an error, never both

    a_payload_stable: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        (req_i && !ack_o) ##1 (req_i && !ack_o) |-> $stable(req_payload_i));

endmodule : pbus_req_intake

// File: hdl/pbus_pkg.sv
/*
 * peripheral bus types
 * opcode, response code and intake state enums, plus the request,
 * access and response structs passed between the bus blocks
 */
`include "pbus_macros.svh"

package pbus_pkg;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    typedef enum logic {
        PBUS_READ  = 1'b0,
        PBUS_WRITE = 1'b1
    } pbus_op_e;

    typedef enum logic {
        PBUS_OKAY   = 1'b0,
        PBUS_DECERR = 1'b1              // unmapped address
    } pbus_resp_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,                // waiting for req
        ACCESS   = 2'd1,                // request captured, decoding
        WAIT_RSP = 2'd2,                // strobe sent, slave busy
        HOLD_ACK = 2'd3                 // ack high until req drops
    } pbus_state_e;

    //////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////

    // host request, 49 bits
    typedef struct packed {
        pbus_op_e                 op;
        logic [`PBUS_ADDR_W-1:0]  addr;
        logic [`PBUS_DATA_W-1:0]  wdata;
    } pbus_req_t;

    // decoded access broadcast to the slaves, 35 bits
    typedef struct packed {
        pbus_op_e                 op;
        logic [`PBUS_REG_W-1:0]   reg_off;    // register inside the slave
        logic [`PBUS_DATA_W-1:0]  wdata;
    } pbus_acc_t;

    // response back to the host, 33 bits
    typedef struct packed {
        pbus_resp_e               resp;
        logic [`PBUS_DATA_W-1:0]  rdata;
    } pbus_rsp_t;

endpackage : pbus_pkg

// File: hdl/pbus_macros.svh
/*
 * peripheral bus constants
 * bus widths, slave memory map, register offsets and timer control bits
 */
`ifndef PBUS_MACROS_SVH
`define PBUS_MACROS_SVH

`define PBUS_ADDR_W     16      // byte address
`define PBUS_DATA_W     32      // single word access
`define PBUS_NUM_SLV    3       // gpio, tim0, tim1
`define PBUS_NUM_IRQ    3       // {tim1, tim0, gpio}
`define PBUS_GPIO_W     8

// memory map: addr[15:12] must be zero, addr[11:8] picks the slave
`define PBUS_SLV_LSB    8
`define PBUS_SLV_W      4
`define PBUS_REG_LSB    2       // word aligned registers, addr[3:2]
`define PBUS_REG_W      2

`define PBUS_TIM_CTRL     2'd0
`define PBUS_TIM_LOAD     2'd1
`define PBUS_TIM_COUNT    2'd2  // read only
`define PBUS_TIM_STATUS   2'd3  // bit 0 pending, write 1 clears

`define PBUS_GPIO_OUT     2'd0
`define PBUS_GPIO_IN      2'd1  // read only
`define PBUS_GPIO_IRQ_EN  2'd2
`define PBUS_GPIO_STATUS  2'd3  // change flags, write 1 clears

`define PBUS_TIM_EN       0     // ctrl bit positions
`define PBUS_TIM_RELOAD   1
`define PBUS_TIM_IRQ_EN   2

`endif
